/* Bender.yml */
package:
  name: aes_block

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/aes_pkg.sv
      - design/ahb_reg_decode.sv
      - design/aes_round_engine.sv
      - design/ahb_result_writer.sv
      - design/aes_block.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_ahb_mem_model.sv
      - tb/tb_aes_block.sv

/* design/aes_block.sv */
// Up to three blocks in flight: one pending in decode, one in the engine, one being written
`timescale 1ns/10ps
`default_nettype none

module aes_block (
  input  logic              tb_HCLK,
  input  logic              rst_n,
  // Register slave port
  input  logic              hsel,
  input  aes_pkg::addr_t    haddr,
  input  logic              hwrite,
  input  aes_pkg::htrans_t  htrans,
  input  logic              hready,
  input  aes_pkg::word_t    hwdata,
  output logic              hreadyout,
  output logic              hresp,
  output aes_pkg::word_t    hrdata,
  // Ciphertext master port
  output aes_pkg::addr_t    m_haddr,
  output logic              m_hwrite,
  output aes_pkg::htrans_t  m_htrans,
  output aes_pkg::word_t    m_hwdata,
  input  logic              m_hready,
  input  logic              m_hresp
);

  aes_pkg::aes_job_t    job;
  logic                 job_valid;
  logic                 job_ready;
  aes_pkg::aes_result_t res;
  logic                 res_valid;
  logic                 res_ready;
  aes_pkg::word_t       blocks_done;

  // Decode stage
  ahb_reg_decode decode_i (
    .tb_HCLK     (tb_HCLK),
    .rst_n       (rst_n),
    .hsel        (hsel),
    .haddr       (haddr),
    .hwrite      (hwrite),
    .htrans      (htrans),
    .hready      (hready),
    .hwdata      (hwdata),
    .job_ready   (job_ready),
    .blocks_done (blocks_done),
    .hreadyout   (hreadyout),
    .hresp       (hresp),
    .hrdata      (hrdata),
    .job         (job),
    .job_valid   (job_valid)
  );

  // Execute stage
  aes_round_engine engine_i (
    .tb_HCLK   (tb_HCLK),
    .rst_n     (rst_n),
    .job       (job),
    .job_valid (job_valid),
    .res_ready (res_ready),
    .job_ready (job_ready),
    .res       (res),
    .res_valid (res_valid)
  );

  // Result stage
  ahb_result_writer writer_i (
    .tb_HCLK     (tb_HCLK),
    .rst_n       (rst_n),
    .res         (res),
    .res_valid   (res_valid),
    .m_hready    (m_hready),
    .m_hresp     (m_hresp),
    .res_ready   (res_ready),
    .m_haddr     (m_haddr),
    .m_hwrite    (m_hwrite),
    .m_htrans    (m_htrans),
    .m_hwdata    (m_hwdata),
    .blocks_done (blocks_done)
  );

endmodule

`default_nettype wire

/* design/aes_cfg.svh */
// Offsets assume word access only (HSIZE is not decoded); AES_BUS_W must stay 32 for AES words
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// Bus word width, shared by both AHB-Lite ports
`define AES_BUS_W 32

// One AES block is four bus words
`define AES_BLOCK_W (4 * `AES_BUS_W)

// AES-128 round count
`define AES_ROUNDS 10

// Status register, reads the finished block count
`define AES_REG_STATUS 'h00

// Key words 0x04 to 0x10, first word is most significant
`define AES_REG_KEY 'h04

// Counter words 0x14 to 0x20, word 3 auto-increments
`define AES_REG_CTR 'h14

// Destination byte address, advances by one block per job
`define AES_REG_DEST 'h34

// Plaintext words 0x38 to 0x44, write to the last word starts a job
`define AES_REG_PT 'h38

`endif

/* design/aes_pkg.sv */
// S-box is computed by GF(2^8) inversion, so every call builds a deep combinational cone
`default_nettype none

`include "aes_cfg.svh"

package aes_pkg;

  // Bus word and byte address
  typedef logic [`AES_BUS_W-1:0] word_t;
  typedef logic [`AES_BUS_W-1:0] addr_t;

  // Word at the lowest address sits in the top bits
  typedef logic [`AES_BLOCK_W-1:0] block_t;

  typedef logic [7:0] byte_t;

  // AHB-Lite transfer type
  typedef enum logic [1:0] {
    TR_IDLE   = 2'b00,
    TR_BUSY   = 2'b01,
    TR_NONSEQ = 2'b10,
    TR_SEQ    = 2'b11
  } htrans_t;

  // One encryption request from the register side
  typedef struct packed {
    block_t key;
    block_t ctr;
    block_t pt;
    addr_t  dest;
  } aes_job_t;

  // Ciphertext and where it goes
  typedef struct packed {
    block_t ct;
    addr_t  dest;
  } aes_result_t;

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_RUN,
    ENG_HOLD
  } engine_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR,
    WR_DATA
  } writer_state_t;

  // Multiply by x modulo the AES polynomial
  function automatic byte_t xtime(input byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Shift-and-add multiply in GF(2^8)
  function automatic byte_t gf_mul(input byte_t a, input byte_t b);
    byte_t acc;
    byte_t sh;
    acc = 8'h00;
    sh  = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        acc = acc ^ sh;
      sh = xtime(sh);
    end
    return acc;
  endfunction

  // Inverse as b^254, zero maps to zero
  function automatic byte_t gf_inv(input byte_t b);
    byte_t sq;
    byte_t res;
    sq  = b;
    res = 8'h01;
    for (int i = 1; i < 8; i++)
    begin
      sq  = gf_mul(sq, sq);
      res = gf_mul(res, sq);
    end
    return res;
  endfunction

  // Inversion followed by the affine map
  function automatic byte_t sbox(input byte_t b);
    byte_t v;
    v = gf_inv(b);
    return v ^ {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^ {v[4:0], v[7:5]} ^ {v[3:0], v[7:4]} ^ 8'h63;
  endfunction

endpackage

`default_nettype wire

/* design/aes_round_engine.sv */
// One round per cycle, result 11 cycles after accept; round keys are expanded on the fly
`timescale 1ns/10ps
`default_nettype none

`include "aes_cfg.svh"

module aes_round_engine (
  input  logic                  tb_HCLK,
  input  logic                  rst_n,
  input  aes_pkg::aes_job_t     job,
  input  logic                  job_valid,
  input  logic                  res_ready,
  output logic                  job_ready,
  output aes_pkg::aes_result_t  res,
  output logic                  res_valid
);

  aes_pkg::engine_state_t eng_state;
  logic [3:0]             round_q;
  aes_pkg::byte_t         rcon_q;
  aes_pkg::block_t        state_q;
  aes_pkg::block_t        rkey_q;
  aes_pkg::block_t        pt_q;
  aes_pkg::addr_t         dest_q;

  aes_pkg::block_t sub_sh;
  aes_pkg::block_t mixed;
  aes_pkg::block_t round_out;
  aes_pkg::block_t next_key;
  logic            last_round;
  logic            accept;

  // Byte i of the state sits at bits [127-8i -: 8], column-major
  function automatic aes_pkg::block_t sub_bytes(input aes_pkg::block_t s);
    aes_pkg::block_t o;
    for (int i = 0; i < 16; i++)
      o[8*i +: 8] = aes_pkg::sbox(s[8*i +: 8]);
    return o;
  endfunction

  // Row r rotates left by r columns
  function automatic aes_pkg::block_t shift_rows(input aes_pkg::block_t s);
    aes_pkg::block_t o;
    for (int c = 0; c < 4; c++)
      for (int r = 0; r < 4; r++)
        o[8*(15-r-4*c) +: 8] = s[8*(15-r-4*((c+r)%4)) +: 8];
    return o;
  endfunction

  function automatic aes_pkg::word_t mix_column(input aes_pkg::word_t w);
    aes_pkg::byte_t a0;
    aes_pkg::byte_t a1;
    aes_pkg::byte_t a2;
    aes_pkg::byte_t a3;
    a0 = w[31:24];
    a1 = w[23:16];
    a2 = w[15:8];
    a3 = w[7:0];
    // Matrix rows 2 3 1 1, rotated per output byte
    return {aes_pkg::xtime(a0) ^ aes_pkg::xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ aes_pkg::xtime(a1) ^ aes_pkg::xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ aes_pkg::xtime(a2) ^ aes_pkg::xtime(a3) ^ a3,
            aes_pkg::xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_pkg::xtime(a3)};
  endfunction

  function automatic aes_pkg::block_t mix_columns(input aes_pkg::block_t s);
    aes_pkg::block_t o;
    for (int c = 0; c < 4; c++)
      o[32*(3-c) +: 32] = mix_column(s[32*(3-c) +: 32]);
    return o;
  endfunction

  // Next round key from RotWord, SubWord and the round constant
  function automatic aes_pkg::block_t expand_key(input aes_pkg::block_t k,
                                                 input aes_pkg::byte_t rc);
    aes_pkg::word_t t;
    aes_pkg::word_t w0;
    aes_pkg::word_t w1;
    aes_pkg::word_t w2;
    aes_pkg::word_t w3;
    t  = {aes_pkg::sbox(k[23:16]) ^ rc, aes_pkg::sbox(k[15:8]),
          aes_pkg::sbox(k[7:0]), aes_pkg::sbox(k[31:24])};
    w0 = k[127:96] ^ t;
    w1 = k[95:64] ^ w0;
    w2 = k[63:32] ^ w1;
    w3 = k[31:0] ^ w2;
    return {w0, w1, w2, w3};
  endfunction

  // Round datapath, MixColumns dropped in the last round
  assign last_round = (round_q == 4'(`AES_ROUNDS));
  assign sub_sh     = shift_rows(sub_bytes(state_q));
  assign mixed      = last_round ? sub_sh : mix_columns(sub_sh);
  assign round_out  = mixed ^ rkey_q;
  assign next_key   = expand_key(rkey_q, rcon_q);

  // New job may enter as the finished result leaves
  assign job_ready = (eng_state == aes_pkg::ENG_IDLE) ||
                     ((eng_state == aes_pkg::ENG_HOLD) && res_ready);
  assign accept    = job_valid && job_ready;

  assign res_valid = (eng_state == aes_pkg::ENG_HOLD);
  assign res.ct    = state_q;
  assign res.dest  = dest_q;

  always_ff @(posedge tb_HCLK)
  begin
    if (!rst_n)
    begin
      eng_state <= aes_pkg::ENG_IDLE;
      round_q   <= '0;
    end
    else
    begin
      case (eng_state)
        aes_pkg::ENG_IDLE:
          if (accept)
          begin
            eng_state <= aes_pkg::ENG_RUN;
            round_q   <= '0;
          end
        aes_pkg::ENG_RUN:
        begin
          round_q <= round_q + 1'b1;
          if (last_round)
            eng_state <= aes_pkg::ENG_HOLD;
        end
        aes_pkg::ENG_HOLD:
          if (accept)
          begin
            eng_state <= aes_pkg::ENG_RUN;
            round_q   <= '0;
          end
          else if (res_ready)
            eng_state <= aes_pkg::ENG_IDLE;
        default:
          eng_state <= aes_pkg::ENG_IDLE;
      endcase
    end
  end

  // State and key registers
  always_ff @(posedge tb_HCLK)
  begin
    if (accept)
    begin
      state_q <= job.ctr;
      rkey_q  <= job.key;
      pt_q    <= job.pt;
      dest_q  <= job.dest;
      rcon_q  <= 8'h01;
    end
    else if (eng_state == aes_pkg::ENG_RUN)
    begin
      // Round 0 is the initial AddRoundKey
      if (round_q == 4'd0)
        state_q <= state_q ^ rkey_q;
      else if (last_round)
        state_q <= round_out ^ pt_q;
      else
        state_q <= round_out;
      rkey_q <= next_key;
      rcon_q <= aes_pkg::xtime(rcon_q);
    end
  end

endmodule

`default_nettype wire

/* design/ahb_reg_decode.sv */
// Decodes only haddr[7:0] for any selected NONSEQ transfer; key and plaintext are write-only
`timescale 1ns/10ps
`default_nettype none

`include "aes_cfg.svh"

module ahb_reg_decode (
  input  logic               tb_HCLK,
  input  logic               rst_n,
  input  logic               hsel,
  input  aes_pkg::addr_t     haddr,
  input  logic               hwrite,
  input  aes_pkg::htrans_t   htrans,
  input  logic               hready,
  input  aes_pkg::word_t     hwdata,
  input  logic               job_ready,
  input  aes_pkg::word_t     blocks_done,
  output logic               hreadyout,
  output logic               hresp,
  output aes_pkg::word_t     hrdata,
  output aes_pkg::aes_job_t  job,
  output logic               job_valid
);

  // Data phase bookkeeping
  logic       dp_valid;
  logic       dp_write;
  logic [7:0] dp_off;

  aes_pkg::word_t key_q [4];
  aes_pkg::word_t ctr_q [4];
  aes_pkg::word_t pt_q  [3];
  aes_pkg::addr_t dest_q;

  logic wr_done;
  logic last_pt;
  logic accept;

  assign last_pt = (dp_off == 8'(`AES_REG_PT + 12));

  // Stall the start write while the previous job still waits for the engine
  assign hreadyout = !(dp_valid && dp_write && last_pt && job_valid);
  assign hresp     = 1'b0;

  assign wr_done = dp_valid && dp_write && hreadyout;
  assign accept  = job_valid && job_ready;

  // Address phase is taken only when the bus is ready
  always_ff @(posedge tb_HCLK)
  begin
    if (!rst_n)
      dp_valid <= 1'b0;
    else if (hready)
      dp_valid <= hsel && (htrans == aes_pkg::TR_NONSEQ);
  end

  always_ff @(posedge tb_HCLK)
  begin
    if (hready)
    begin
      dp_write <= hwrite;
      dp_off   <= haddr[7:0];
    end
  end

  // Register file, a bus write wins over the auto-advance in the same cycle
  always_ff @(posedge tb_HCLK)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 4; i++)
      begin
        key_q[i] <= '0;
        ctr_q[i] <= '0;
      end
      for (int i = 0; i < 3; i++)
        pt_q[i] <= '0;
      dest_q <= '0;
    end
    else
    begin
      // Next block gets the following counter and address
      if (accept)
      begin
        ctr_q[3] <= ctr_q[3] + 1'b1;
        dest_q   <= dest_q + aes_pkg::addr_t'(`AES_BLOCK_W / 8);
      end
      if (wr_done)
      begin
        for (int i = 0; i < 4; i++)
        begin
          if (dp_off == 8'(`AES_REG_KEY + 4 * i))
            key_q[i] <= hwdata;
          if (dp_off == 8'(`AES_REG_CTR + 4 * i))
            ctr_q[i] <= hwdata;
        end
        for (int i = 0; i < 3; i++)
          if (dp_off == 8'(`AES_REG_PT + 4 * i))
            pt_q[i] <= hwdata;
        if (dp_off == 8'(`AES_REG_DEST))
          dest_q <= hwdata;
      end
    end
  end

  // Pending job flag
  always_ff @(posedge tb_HCLK)
  begin
    if (!rst_n)
      job_valid <= 1'b0;
    else if (wr_done && last_pt)
      job_valid <= 1'b1;
    else if (accept)
      job_valid <= 1'b0;
  end

  // Snapshot keeps the job stable while new plaintext is written
  always_ff @(posedge tb_HCLK)
  begin
    if (wr_done && last_pt)
    begin
      job.key  <= {key_q[0], key_q[1], key_q[2], key_q[3]};
      job.ctr  <= {ctr_q[0], ctr_q[1], ctr_q[2], ctr_q[3]};
      job.pt   <= {pt_q[0], pt_q[1], pt_q[2], hwdata};
      job.dest <= dest_q;
    end
  end

  // Read mux from the registered offset
  always_comb
  begin
    hrdata = '0;
    if (dp_valid && !dp_write)
    begin
      if (dp_off == 8'(`AES_REG_STATUS))
        hrdata = blocks_done;
      for (int i = 0; i < 4; i++)
        if (dp_off == 8'(`AES_REG_CTR + 4 * i))
          hrdata = ctr_q[i];
      if (dp_off == 8'(`AES_REG_DEST))
        hrdata = dest_q;
    end
  end

endmodule

`default_nettype wire

/* design/ahb_result_writer.sv */
// Four single NONSEQ word writes per block; HRESP errors are not retried or reported
`timescale 1ns/10ps
`default_nettype none

`include "aes_cfg.svh"

module ahb_result_writer (
  input  logic                  tb_HCLK,
  input  logic                  rst_n,
  input  aes_pkg::aes_result_t  res,
  input  logic                  res_valid,
  input  logic                  m_hready,
  input  logic                  m_hresp,
  output logic                  res_ready,
  output aes_pkg::addr_t        m_haddr,
  output logic                  m_hwrite,
  output aes_pkg::htrans_t      m_htrans,
  output aes_pkg::word_t        m_hwdata,
  output aes_pkg::word_t        blocks_done
);

  aes_pkg::writer_state_t wr_state;

  // Beat in address phase and beat in data phase
  logic [1:0] beat_q;
  logic [1:0] data_q;

  aes_pkg::block_t ct_q;
  aes_pkg::addr_t  base_q;
  logic            err_first;

  assign res_ready = (wr_state == aes_pkg::WR_IDLE);

  // First cycle of an ERROR response, the pending address may be dropped to IDLE
  assign err_first = m_hresp && !m_hready;

  assign m_htrans = ((wr_state == aes_pkg::WR_ADDR) && !err_first) ?
                    aes_pkg::TR_NONSEQ : aes_pkg::TR_IDLE;
  assign m_hwrite = (wr_state == aes_pkg::WR_ADDR);
  assign m_haddr  = base_q + aes_pkg::addr_t'(beat_q) * (`AES_BUS_W / 8);

  // Data lags address by one phase
  assign m_hwdata = ct_q[`AES_BLOCK_W - `AES_BUS_W * (data_q + 1) +: `AES_BUS_W];

  always_ff @(posedge tb_HCLK)
  begin
    if (!rst_n)
    begin
      wr_state    <= aes_pkg::WR_IDLE;
      beat_q      <= '0;
      blocks_done <= '0;
    end
    else
    begin
      case (wr_state)
        aes_pkg::WR_IDLE:
          if (res_valid)
          begin
            wr_state <= aes_pkg::WR_ADDR;
            beat_q   <= '0;
          end
        aes_pkg::WR_ADDR:
          if (m_hready)
          begin
            beat_q <= beat_q + 1'b1;
            if (beat_q == 2'd3)
              wr_state <= aes_pkg::WR_DATA;
          end
        aes_pkg::WR_DATA:
          // Last data phase done, block is in memory
          if (m_hready)
          begin
            wr_state    <= aes_pkg::WR_IDLE;
            blocks_done <= blocks_done + 1'b1;
          end
        default:
          wr_state <= aes_pkg::WR_IDLE;
      endcase
    end
  end

  // Captured result and data-phase index
  always_ff @(posedge tb_HCLK)
  begin
    if (res_valid && res_ready)
    begin
      ct_q   <= res.ct;
      base_q <= res.dest;
    end
    if ((wr_state == aes_pkg::WR_ADDR) && m_hready)
      data_q <= beat_q;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+design
design/aes_pkg.sv
design/ahb_reg_decode.sv
design/aes_round_engine.sv
design/ahb_result_writer.sv
design/aes_block.sv
tb/tb_ahb_mem_model.sv
tb/tb_aes_block.sv

/* tb/tb_aes_block.sv */
// Single master with non-pipelined register accesses; all destinations must stay below 0x400
`timescale 1ns/10ps
`default_nettype none

`include "aes_cfg.svh"

module tb_aes_block;

  localparam int NUM_ROWS    = 2;
  localparam int CLK_PERIOD  = 4;
  // Rows x 4 blocks x 200 cycles
  localparam int WATCHDOG_NS = NUM_ROWS * 4 * 200 * CLK_PERIOD;

  // One known-answer row
  typedef struct packed {
    aes_pkg::block_t key;
    aes_pkg::block_t ctr;
    aes_pkg::block_t pt;
    aes_pkg::addr_t  dest;
    aes_pkg::block_t ct;
  } vector_t;

  logic               tb_HCLK;
  logic               rst_n;
  logic               hsel;
  aes_pkg::addr_t     haddr;
  logic               hwrite;
  aes_pkg::htrans_t   htrans;
  logic               hready;
  aes_pkg::word_t     hwdata;
  logic               hreadyout;
  logic               hresp;
  aes_pkg::word_t     hrdata;
  aes_pkg::addr_t     m_haddr;
  logic               m_hwrite;
  aes_pkg::htrans_t   m_htrans;
  aes_pkg::word_t     m_hwdata;
  logic               m_hready;
  logic               m_hresp;
  logic [31:0]        mem_writes;

  vector_t     vectors [NUM_ROWS];
  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          jobs;

  // Only one slave on the register bus
  assign hready = hreadyout;

  aes_block dut_i (
    .tb_HCLK   (tb_HCLK),
    .rst_n     (rst_n),
    .hsel      (hsel),
    .haddr     (haddr),
    .hwrite    (hwrite),
    .htrans    (htrans),
    .hready    (hready),
    .hwdata    (hwdata),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .hrdata    (hrdata),
    .m_haddr   (m_haddr),
    .m_hwrite  (m_hwrite),
    .m_htrans  (m_htrans),
    .m_hwdata  (m_hwdata),
    .m_hready  (m_hready),
    .m_hresp   (m_hresp)
  );

  tb_ahb_mem_model mem_i (
    .tb_HCLK (tb_HCLK),
    .rst_n   (rst_n),
    .haddr   (m_haddr),
    .hwrite  (m_hwrite),
    .htrans  (m_htrans),
    .hwdata  (m_hwdata),
    .hready  (m_hready),
    .hresp   (m_hresp),
    .writes  (mem_writes)
  );

  initial
  begin
    tb_HCLK = 1'b0;
    forever #(CLK_PERIOD / 2) tb_HCLK = ~tb_HCLK;
  end

  // Galois LFSR stepped once per bit taken
  function automatic aes_pkg::word_t rand_word();
    aes_pkg::word_t w;
    for (int i = 0; i < 32; i++)
    begin
      w[i] = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return w;
  endfunction

  function automatic aes_pkg::block_t rand_block();
    aes_pkg::block_t b;
    for (int i = 0; i < 4; i++)
      b[127 - 32 * i -: 32] = rand_word();
    return b;
  endfunction

  function automatic aes_pkg::word_t mem_word(input aes_pkg::addr_t addr);
    return mem_i.mem[addr[9:2]];
  endfunction

  function automatic logic landed(input aes_pkg::addr_t addr);
    return mem_i.written[addr[9:2]];
  endfunction

  task automatic check(input string name, input aes_pkg::word_t expected,
                       input aes_pkg::word_t actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[ERROR] %s: expected %08h, actual %08h", name, expected, actual);
    end
  endtask

  // HREADY is sampled mid-cycle and the phase ends on the next edge
  task automatic wait_ready();
    @(negedge tb_HCLK);
    while (!hreadyout)
      @(negedge tb_HCLK);
    @(posedge tb_HCLK);
  endtask

  // One single transfer with its address and data phase
  task automatic bus_access(input logic write, input aes_pkg::addr_t addr,
                            input aes_pkg::word_t wdata, output aes_pkg::word_t rdata);
    hsel   = 1'b1;
    haddr  = addr;
    hwrite = write;
    htrans = aes_pkg::TR_NONSEQ;
    wait_ready();
    #1;
    hsel   = 1'b0;
    htrans = aes_pkg::TR_IDLE;
    hwdata = wdata;
    // Start write may be stalled here by a pending job
    @(negedge tb_HCLK);
    while (!hreadyout)
      @(negedge tb_HCLK);
    rdata = hrdata;
    // Slave answers OKAY only
    check("register bus response", 1'b0, hresp);
    @(posedge tb_HCLK);
    #1;
  endtask

  task automatic reg_write(input aes_pkg::addr_t addr, input aes_pkg::word_t data);
    aes_pkg::word_t unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_read(input aes_pkg::addr_t addr, output aes_pkg::word_t data);
    bus_access(1'b0, addr, '0, data);
  endtask

  // Lowest offset gets the top word
  task automatic write_block(input aes_pkg::addr_t base, input aes_pkg::block_t b);
    for (int i = 0; i < 4; i++)
      reg_write(base + 4 * i, b[127 - 32 * i -: 32]);
  endtask

  // Poll status until n blocks are in memory
  task automatic wait_blocks(input int n);
    aes_pkg::word_t status;
    status = '0;
    while (status < n)
      reg_read(`AES_REG_STATUS, status);
    check("status block count", n, status);
    check("memory write count", 4 * n, mem_writes);
  endtask

  // Destination advances on the edge where the job is accepted
  task automatic wait_accept(input aes_pkg::addr_t dest);
    aes_pkg::word_t value;
    reg_read(`AES_REG_DEST, value);
    while (value != dest)
      reg_read(`AES_REG_DEST, value);
  endtask

  task automatic check_advance(input string name, input aes_pkg::word_t ctr3,
                               input aes_pkg::addr_t dest);
    aes_pkg::word_t value;
    reg_read(`AES_REG_CTR + 12, value);
    check({name, " counter word 3"}, ctr3, value);
    reg_read(`AES_REG_DEST, value);
    check({name, " destination"}, dest, value);
  endtask

  task automatic check_memory(input string name, input aes_pkg::addr_t base,
                              input aes_pkg::block_t expected);
    for (int i = 0; i < 4; i++)
      check($sformatf("%s word %0d", name, i), expected[127 - 32 * i -: 32],
            mem_word(base + 4 * i));
  endtask

  initial
  begin
    aes_pkg::block_t pt;
    aes_pkg::block_t pts [3];
    aes_pkg::word_t  value;
    vector_t         v;
    string           name;
    // FIPS-197 C.1 and B vectors with the counter block as cipher input
    vectors[0] = {128'h000102030405060708090a0b0c0d0e0f, 128'h00112233445566778899aabbccddeeff,
                  128'h0, 32'h0000_0100, 128'h69c4e0d86a7b0430d8cdb78070b4c55a};
    vectors[1] = {128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h3243f6a8885a308d313198a2e0370734,
                  128'h0, 32'h0000_0200, 128'h3925841d02dc09fbdc118597196a0b32};
    lfsr   = 32'ha545_8353;
    errors = 0;
    checks = 0;
    jobs   = 0;
    rst_n  = 1'b0;
    hsel   = 1'b0;
    haddr  = '0;
    hwrite = 1'b0;
    htrans = aes_pkg::TR_IDLE;
    hwdata = '0;
    repeat (4) @(posedge tb_HCLK);
    #1;
    rst_n = 1'b1;
    // Nothing done and nothing written after reset
    check("hreadyout after reset", 1'b1, hreadyout);
    reg_read(`AES_REG_STATUS, value);
    check("status after reset", 0, value);
    check("memory writes after reset", 0, mem_writes);
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      v    = vectors[r];
      name = $sformatf("row %0d", r);
      write_block(`AES_REG_KEY, v.key);
      write_block(`AES_REG_CTR, v.ctr);
      reg_write(`AES_REG_DEST, v.dest);
      // Zero plaintext leaves the bare keystream
      write_block(`AES_REG_PT, v.pt);
      jobs++;
      wait_blocks(jobs);
      check_memory({name, " known answer"}, v.dest, v.pt ^ v.ct);
      check_advance({name, " known answer"}, v.ctr[31:0] + 1, v.dest + 16);
      // Same counter again with random plaintext
      write_block(`AES_REG_CTR, v.ctr);
      pt = rand_block();
      write_block(`AES_REG_PT, pt);
      jobs++;
      wait_blocks(jobs);
      check_memory({name, " keystream xor"}, v.dest + 16, pt ^ v.ct);
      check_advance({name, " keystream xor"}, v.ctr[31:0] + 1, v.dest + 32);
      // Plaintext-only jobs back to back so later start writes stall
      for (int k = 0; k < 3; k++)
        write_block(`AES_REG_PT, rand_block());
      jobs += 3;
      wait_blocks(jobs);
      check_advance({name, " auto-advance"}, v.ctr[31:0] + 4, v.dest + 80);
      for (int i = 0; i < 12; i++)
        check($sformatf("%s auto-advance landing word %0d", name, i), 1,
              landed(v.dest + 32 + 4 * i));
      // Counter rewrite once the previous job has left decode
      for (int k = 0; k < 3; k++)
      begin
        write_block(`AES_REG_CTR, v.ctr);
        pts[k] = rand_block();
        write_block(`AES_REG_PT, pts[k]);
        wait_accept(v.dest + 16 * (6 + k));
      end
      jobs += 3;
      wait_blocks(jobs);
      for (int k = 0; k < 3; k++)
        check_memory($sformatf("%s in flight block %0d", name, k), v.dest + 16 * (5 + k),
                     pts[k] ^ v.ct);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/tb_ahb_mem_model.sv */
// Word memory over the low 1 KiB only, writes above it are counted but not stored; 0 to 3 waits
`timescale 1ns/10ps
`default_nettype none

module tb_ahb_mem_model (
  input  logic             tb_HCLK,
  input  logic             rst_n,
  input  aes_pkg::addr_t   haddr,
  input  logic             hwrite,
  input  aes_pkg::htrans_t htrans,
  input  aes_pkg::word_t   hwdata,
  output logic             hready,
  output logic             hresp,
  output logic [31:0]      writes
);

  // Storage and a flag per word that shows it was written
  aes_pkg::word_t mem     [256];
  logic           written [256];

  // Data phase bookkeeping
  logic           dp_act;
  logic           dp_write;
  aes_pkg::addr_t dp_addr;
  logic [1:0]     waits_left;
  logic [1:0]     wait_draw;
  logic [31:0]    lfsr;

  // Two LFSR bits per draw, one step per bit
  function automatic logic [1:0] draw_wait();
    logic [1:0] w;
    for (int i = 0; i < 2; i++)
    begin
      w[i] = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return w;
  endfunction

  // OKAY only
  assign hresp = 1'b0;

  initial
  begin
    hready = 1'b1;
    writes = '0;
    dp_act = 1'b0;
    lfsr   = 32'ha545_8353;
  end

  always @(posedge tb_HCLK)
  begin
    if (!rst_n)
    begin
      dp_act     <= 1'b0;
      hready     <= #1 1'b1;
      writes     <= '0;
      waits_left <= 2'd0;
      lfsr       = 32'ha545_8353;
      for (int i = 0; i < 256; i++)
        written[i] <= 1'b0;
    end
    else
    begin
      // Data phase ends on this edge
      if (dp_act && hready && dp_write)
      begin
        writes <= writes + 1'b1;
        if (dp_addr[31:10] == '0)
        begin
          mem[dp_addr[9:2]]     <= hwdata;
          written[dp_addr[9:2]] <= 1'b1;
        end
      end
      if (hready)
      begin
        // Address phase sampled here
        dp_act   <= (htrans == aes_pkg::TR_NONSEQ);
        dp_addr  <= haddr;
        dp_write <= hwrite;
        if (htrans == aes_pkg::TR_NONSEQ)
        begin
          wait_draw  = draw_wait();
          waits_left <= wait_draw;
          hready     <= #1 (wait_draw == 2'd0);
        end
      end
      else
      begin
        // Count down the inserted wait states
        waits_left <= waits_left - 1'b1;
        if (waits_left == 2'd1)
          hready <= #1 1'b1;
      end
    end
  end

endmodule

`default_nettype wire
